//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tbI2cTop
FILELIST  := sim.f
OBJDIR    := obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- design/i2cBitEngine.sv
// I2C bit engine: runs one START, STOP, byte write or byte read on open-drain SCL and SDA
module i2cBitEngine #(
	parameter int pDivBits = 16
)(
	input  logic                iSysClk,
	input  logic                rstN,
	input  logic [pDivBits-1:0] div,	// Quarter bit is div+1 cycles
	input  logic                sdaIn,	// Resolved SDA line
	output logic                sclOe,	// High pulls SCL low
	output logic                sdaOe,	// High pulls SDA low
	i2cBitIf.eng                bitIf
);
	import i2cProtoPkg::*;

	// Command context
	i2cCmdT              cmdR;
	logic [7:0]          txR;
	logic                ackOutR;
	logic [7:0]          rxR;
	logic                ackInR;
	logic                busyR;
	logic                doneR;
	// Quarter and bit position
	logic [pDivBits-1:0] qCnt;
	logic [1:0]          phase;	// 0 low, 1-2 high, 3 low for data bits
	logic [3:0]          bitCnt;	// 0-7 data, 8 ACK
	logic                tick;	// Last cycle of a quarter
	logic                lastQ;
	logic                step;	// Load outputs for a new quarter
	// Next quarter selection
	i2cCmdT              selCmd;
	logic [7:0]          selTx;
	logic                selAck;
	logic [1:0]          selPh;
	logic [3:0]          selBit;
	logic                sclNxt;
	logic                sdaNxt;

	assign bitIf.busy   = busyR;
	assign bitIf.done   = doneR;
	assign bitIf.rxByte = rxR;
	assign bitIf.ackIn  = ackInR;

	assign tick  = busyR && (qCnt >= div);	// >= copes with div lowered mid command
	assign lastQ = (phase == 2'd3) &&
		((cmdR == cmdStart) || (cmdR == cmdStop) || (bitCnt == 4'd8));
	assign step  = bitIf.go || (tick && !lastQ);

	// ----------------------------------------------------------
	// Line levels for the quarter about to start
	// ----------------------------------------------------------
	always_comb
	begin
		selCmd = bitIf.go ? bitIf.cmd : cmdR;
		selTx  = bitIf.go ? bitIf.txByte : txR;
		selAck = bitIf.go ? bitIf.ackOut : ackOutR;
		selPh  = bitIf.go ? 2'd0 : phase + 2'd1;
		selBit = bitIf.go ? 4'd0 : ((phase == 2'd3) ? bitCnt + 4'd1 : bitCnt);
		sclNxt = sclOe;
		sdaNxt = sdaOe;
		case (selCmd)
			cmdStart:
			begin
				case (selPh)
					2'd0: sdaNxt = 1'b0;	// SDA up first
					2'd1: sclNxt = 1'b0;
					2'd2: sdaNxt = 1'b1;	// SDA falls under high SCL
					default: sclNxt = 1'b1;
				endcase
			end
			cmdStop:
			begin
				case (selPh)
					2'd0:
					begin
						sclNxt = 1'b1;
						sdaNxt = 1'b1;
					end
					2'd1: sclNxt = 1'b0;
					2'd2: sdaNxt = 1'b0;	// SDA rises under high SCL
					default: sdaNxt = 1'b0;
				endcase
			end
			default:	// Byte commands
			begin
				sclNxt = (selPh == 2'd0) || (selPh == 2'd3);
				if (selPh == 2'd0)
				begin
					if (selCmd == cmdWrite)
						sdaNxt = (selBit == 4'd8) ? 1'b0 : !selTx[3'd7 - selBit[2:0]];
					else
						sdaNxt = (selBit == 4'd8) ? selAck : 1'b0;
				end
			end
		endcase
	end

	// ----------------------------------------------------------
	// Timing and outputs
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busyR  <= 1'b0;
			doneR  <= 1'b0;
			cmdR   <= cmdStart;
			qCnt   <= '0;
			phase  <= 2'd0;
			bitCnt <= 4'd0;
			sclOe  <= 1'b0;	// Bus released
			sdaOe  <= 1'b0;
		end
		else
		begin
			doneR <= 1'b0;
			if (bitIf.go)
			begin
				busyR  <= 1'b1;
				cmdR   <= bitIf.cmd;
				qCnt   <= '0;
				phase  <= 2'd0;
				bitCnt <= 4'd0;
			end
			else if (tick)
			begin
				qCnt  <= '0;
				phase <= phase + 2'd1;
				if (phase == 2'd3)
					bitCnt <= bitCnt + 4'd1;
				if (lastQ)
				begin
					busyR <= 1'b0;
					doneR <= 1'b1;
				end
			end
			else if (busyR)
				qCnt <= qCnt + 1'b1;

			if (step)
			begin
				sclOe <= sclNxt;
				sdaOe <= sdaNxt;
			end
		end
	end

	// Byte payload, sampled mid SCL-high
	always_ff @(posedge iSysClk)
	begin
		if (bitIf.go)
		begin
			txR     <= bitIf.txByte;
			ackOutR <= bitIf.ackOut;
		end
		if (tick && (phase == 2'd1) && ((cmdR == cmdWrite) || (cmdR == cmdRead)))
		begin
			if (bitCnt == 4'd8)
				ackInR <= !sdaIn;	// Low means ACK
			else
				rxR <= {rxR[6:0], sdaIn};	// MSB first
		end
	end

	goWhileIdle: assert property (@(posedge iSysClk) disable iff (!rstN)
		bitIf.go |-> !bitIf.busy);

endmodule

//--- design/i2cBitIf.sv
// Internal interfaces: CSR to poll sequencer control path, and poll sequencer to bit engine commands
interface i2cCtrlIf #(
	parameter int pDivBits = 16
) ();
	import i2cProtoPkg::*;

	logic                enable;	// Keep polling
	logic [pDivBits-1:0] div;	// Quarter bit divider
	logic [keyWordW-1:0] keyWord;	// Assembled keypad word
	logic                keyValid;	// One cycle, loads Key and sets done
	logic                nackPulse;	// One cycle, sets nack

	modport csr (output enable, output div, input keyWord, input keyValid, input nackPulse);
	modport seq (input enable, output keyWord, output keyValid, output nackPulse);
endinterface

interface i2cBitIf ();
	import i2cProtoPkg::*;

	i2cCmdT     cmd;
	logic [7:0] txByte;
	logic       ackOut;	// Master ACK after a read byte
	logic       go;	// One cycle, only while idle
	logic       busy;
	logic       done;	// One cycle at command end
	logic [7:0] rxByte;
	logic       ackIn;	// Slave ACK after a written byte

	modport seq (output cmd, output txByte, output ackOut, output go,
		input busy, input done, input rxByte, input ackIn);
	modport eng (input cmd, input txByte, input ackOut, input go,
		output busy, output done, output rxByte, output ackIn);
endinterface

//--- design/i2cBusPkg.sv
// Host bus widths, Wishbone address layout and register map shared by the CSR block and the testbench
package i2cBusPkg;

	// ----------------------------------------------------------
	// Bus widths
	// ----------------------------------------------------------
	localparam int busDataW = 32;	// Wishbone data width
	localparam int busAdrsW = 32;	// Wishbone byte address width
	localparam int blockW   = 24;	// Upper block number field
	localparam int ofsW     = 8;	// Register offset field

	// ----------------------------------------------------------
	// Address word, seen whole or as block plus offset
	// ----------------------------------------------------------
	typedef struct packed {
		logic [blockW-1:0] blockNum;	// Selects the peripheral block
		logic [ofsW-1:0]   regOfs;	// Byte offset inside the block
	} csrAdrsFieldT;

	typedef union packed {
		logic [busAdrsW-1:0] word;	// Raw address from the host
		csrAdrsFieldT        field;
	} csrAdrsT;

	// Register offsets
	localparam logic [ofsW-1:0] CtrlOfs = 8'h00;	// Bit 0 enable
	localparam logic [ofsW-1:0] DivOfs  = 8'h04;	// SCL quarter divider
	localparam logic [ofsW-1:0] KeyOfs  = 8'h80;	// Last keypad word, read only
	localparam logic [ofsW-1:0] StatOfs = 8'h84;	// Sticky flags, write 1 to clear

	// Stat bit positions
	localparam int statDoneBit = 0;
	localparam int statNackBit = 1;
	localparam int statW       = 2;

endpackage

//--- design/i2cCsr.sv
// Wishbone classic register block: holds enable and divider, captures keypad word and sticky flags
module i2cCsr #(
	parameter logic [i2cBusPkg::blockW-1:0] pBlockAdrs = 24'h000004,
	parameter int                           pDivBits   = 16
)(
	input  logic                            iSysClk,
	input  logic                            rstN,
	input  logic                            wbCyc,
	input  logic                            wbStb,
	input  logic                            wbWe,
	input  logic [i2cBusPkg::busAdrsW-1:0]  wbAdr,
	input  logic [i2cBusPkg::busDataW-1:0]  wbDatW,
	output logic [i2cBusPkg::busDataW-1:0]  wbDatR,	// Valid with wbAck
	output logic                            wbAck,
	i2cCtrlIf.csr                           ctrl
);
	import i2cBusPkg::*;
	import i2cProtoPkg::*;

	csrAdrsT             adrs;
	logic                hit;	// Strobe addressed to this block
	logic                wrEn;
	logic                enableR;
	logic [pDivBits-1:0] divR;
	logic [keyWordW-1:0] keyR;
	logic [statW-1:0]    statR;	// done, nack
	logic                statWr;

	// ----------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------
	assign adrs.word = wbAdr;
	// No new hit in the ack cycle, so one strobe gets one ack
	assign hit    = wbCyc && wbStb && !wbAck && (adrs.field.blockNum == pBlockAdrs);
	assign wrEn   = hit && wbWe;
	assign statWr = wrEn && (adrs.field.regOfs == StatOfs);

	assign ctrl.enable = enableR;
	assign ctrl.div    = divR;

	// Bus ack
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			wbAck <= 1'b0;
		else
			wbAck <= hit;
	end

	// ----------------------------------------------------------
	// Control and status registers
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enableR <= 1'b0;
			divR    <= '1;	// Slowest SCL out of reset
			keyR    <= '0;
			statR   <= '0;
		end
		else
		begin
			if (wrEn && (adrs.field.regOfs == CtrlOfs))
				enableR <= wbDatW[0];
			if (wrEn && (adrs.field.regOfs == DivOfs))
				divR <= wbDatW[pDivBits-1:0];
			if (ctrl.keyValid)
				keyR <= ctrl.keyWord;	// Latest word only

			// Set beats clear in the same cycle
			if (ctrl.keyValid)
				statR[statDoneBit] <= 1'b1;
			else if (statWr && wbDatW[statDoneBit])
				statR[statDoneBit] <= 1'b0;

			if (ctrl.nackPulse)
				statR[statNackBit] <= 1'b1;
			else if (statWr && wbDatW[statNackBit])
				statR[statNackBit] <= 1'b0;
		end
	end

	// Read data, registered with the ack
	always_ff @(posedge iSysClk)
	begin
		if (hit && !wbWe)
		begin
			case (adrs.field.regOfs)
				CtrlOfs: wbDatR <= {{(busDataW-1){1'b0}}, enableR};
				DivOfs:  wbDatR <= {{(busDataW-pDivBits){1'b0}}, divR};
				KeyOfs:  wbDatR <= {{(busDataW-keyWordW){1'b0}}, keyR};
				StatOfs: wbDatR <= {{(busDataW-statW){1'b0}}, statR};
				default: wbDatR <= '0;	// Unmapped
			endcase
		end
	end

	// ----------------------------------------------------------
	// Bus protocol checks
	// ----------------------------------------------------------
	ackAfterStb: assert property (@(posedge iSysClk) disable iff (!rstN)
		wbAck |-> $past(wbStb));
	ackOneCycle: assert property (@(posedge iSysClk) disable iff (!rstN)
		wbAck |=> !wbAck);

endmodule

//--- design/i2cPollSeq.sv
// Keypad poll sequencer: repeats START, address read, two data bytes and STOP while enabled
module i2cPollSeq (
	input  logic  iSysClk,
	input  logic  rstN,
	i2cCtrlIf.seq ctrl,
	i2cBitIf.seq  bitIf
);
	import i2cProtoPkg::*;

	seqStateT            state;
	logic                pending;	// Command issued, waiting for done
	logic                cmdState;	// State that owns a bus command
	logic                issue;
	logic                cmdEnd;
	logic                nackSeen;	// Address was not acked
	logic [keyWordW-1:0] wordR;

	assign cmdState = (state == seqStart) || (state == seqAdrs) || (state == seqRdHi) ||
		(state == seqRdLo) || (state == seqStop);
	assign issue  = cmdState && !pending;
	assign cmdEnd = pending && bitIf.done;

	// ----------------------------------------------------------
	// Command selection
	// ----------------------------------------------------------
	always_comb
	begin
		case (state)
			seqStart:         bitIf.cmd = cmdStart;
			seqAdrs:          bitIf.cmd = cmdWrite;
			seqRdHi, seqRdLo: bitIf.cmd = cmdRead;
			default:          bitIf.cmd = cmdStop;
		endcase
	end

	assign bitIf.txByte = {keypadAdrs, 1'b1};	// Only write is the address, R/W = read
	assign bitIf.ackOut = (state == seqRdHi);	// NACK the last byte
	assign ctrl.keyWord = wordR;

	// ----------------------------------------------------------
	// Transaction FSM
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state          <= seqIdle;
			pending        <= 1'b0;
			nackSeen       <= 1'b0;
			bitIf.go       <= 1'b0;
			ctrl.keyValid  <= 1'b0;
			ctrl.nackPulse <= 1'b0;
		end
		else
		begin
			bitIf.go       <= 1'b0;
			ctrl.keyValid  <= 1'b0;
			ctrl.nackPulse <= 1'b0;
			if (issue)
			begin
				bitIf.go <= 1'b1;
				pending  <= 1'b1;
			end
			else if (cmdEnd)
			begin
				pending <= 1'b0;
				case (state)
					seqStart: state <= seqAdrs;
					seqAdrs:
					begin
						if (bitIf.ackIn)
							state <= seqRdHi;
						else
						begin
							nackSeen <= 1'b1;	// Skip the data, go to STOP
							state    <= seqStop;
						end
					end
					seqRdHi: state <= seqRdLo;
					seqRdLo: state <= seqStop;
					default:	// STOP finished
					begin
						ctrl.keyValid  <= !nackSeen;
						ctrl.nackPulse <= nackSeen;
						state          <= seqReport;
					end
				endcase
			end
			else if ((state == seqIdle) && ctrl.enable)
			begin
				nackSeen <= 1'b0;
				state    <= seqStart;
			end
			else if (state == seqReport)
				state <= seqIdle;	// Enable checked again next cycle
		end
	end

	// Word assembly, high byte first
	always_ff @(posedge iSysClk)
	begin
		if (cmdEnd && ((state == seqRdHi) || (state == seqRdLo)))
			wordR <= {wordR[7:0], bitIf.rxByte};
	end

endmodule

//--- design/i2cProtoPkg.sv
// I2C protocol side definitions: bit engine commands, poll sequencer states and keypad addressing
package i2cProtoPkg;

	// ----------------------------------------------------------
	// Bit engine commands
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		cmdStart = 2'd0,	// START condition
		cmdStop  = 2'd1,	// STOP condition
		cmdWrite = 2'd2,	// 8 bits out, slave ACK in
		cmdRead  = 2'd3	// 8 bits in, master ACK out
	} i2cCmdT;

	// ----------------------------------------------------------
	// Poll sequencer states
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		seqIdle   = 3'd0,	// Waiting for enable
		seqStart  = 3'd1,
		seqAdrs   = 3'd2,	// Address byte with read bit
		seqRdHi   = 3'd3,	// High byte, master ACK
		seqRdLo   = 3'd4,	// Low byte, master NACK
		seqStop   = 3'd5,
		seqReport = 3'd6	// Result pulse cycle
	} seqStateT;

	// Keypad slave
	localparam logic [6:0] keypadAdrs = 7'h20;
	localparam int         keyWordW   = 16;	// Two bytes, high first

endpackage

//--- design/i2cTop.sv
// Keypad poller top level: Wishbone register block, poll sequencer and I2C bit engine on plain ports
module i2cTop #(
	parameter logic [i2cBusPkg::blockW-1:0] pBlockAdrs = 24'h000004,
	parameter int                           pDivBits   = 16
)(
	input  logic                           iSysClk,
	input  logic                           rstN,
	// Wishbone classic slave
	input  logic                           wbCyc,
	input  logic                           wbStb,
	input  logic                           wbWe,
	input  logic [i2cBusPkg::busAdrsW-1:0] wbAdr,
	input  logic [i2cBusPkg::busDataW-1:0] wbDatW,
	output logic [i2cBusPkg::busDataW-1:0] wbDatR,
	output logic                           wbAck,
	// I2C lines, open drain
	input  logic                           sdaIn,
	output logic                           sclOe,
	output logic                           sdaOe
);

	// ----------------------------------------------------------
	// Internal buses
	// ----------------------------------------------------------
	i2cCtrlIf #(.pDivBits(pDivBits)) ctrlBus ();
	i2cBitIf bitBus ();

	i2cCsr #(
		.pBlockAdrs (pBlockAdrs),
		.pDivBits   (pDivBits)
	) uCsr (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAdr   (wbAdr),
		.wbDatW  (wbDatW),
		.wbDatR  (wbDatR),
		.wbAck   (wbAck),
		.ctrl    (ctrlBus.csr)
	);

	i2cPollSeq uSeq (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.ctrl    (ctrlBus.seq),
		.bitIf   (bitBus.seq)
	);

	// Divider comes straight from the CSR
	i2cBitEngine #(.pDivBits(pDivBits)) uEng (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.div     (ctrlBus.div),
		.sdaIn   (sdaIn),
		.sclOe   (sclOe),
		.sdaOe   (sdaOe),
		.bitIf   (bitBus.eng)
	);

endmodule

//--- dv/i2cKeypadModel.sv
// Behavioral keypad slave for the testbench, samples the resolved SCL and SDA once per system clock
module i2cKeypadModel (
	input  logic        iSysClk,
	input  logic        rstN,
	input  logic        scl,	// Resolved SCL line
	input  logic        sda,	// Resolved SDA line
	input  logic        respondAdrs,	// Low ignores its own address
	input  logic [15:0] keyWord,	// Word handed out, high byte first
	output logic        sdaPull	// High pulls SDA low
);
	timeunit 1ns;
	timeprecision 100ps;
	import i2cProtoPkg::*;

	typedef enum logic [2:0] {
		modeIdle,	// Not addressed
		modeAdrs,	// Shifting in the address byte
		modeLoad,	// Next SCL fall puts out a data byte
		modeSend,
		modeMack	// Waiting for the master ACK bit
	} modeT;

	modeT       mode;
	logic       sclNow;
	logic       sdaNow;
	logic       sclPrev;
	logic       sdaPrev;
	logic [7:0] inByte;
	logic [7:0] outByte;
	logic       lowByte;	// Second byte of the word
	int         bitCnt;

	// ----------------------------------------------------------
	// Line watcher
	// ----------------------------------------------------------
	initial
	begin
		mode    = modeIdle;
		sdaPull = 1'b0;
		sclPrev = 1'b1;
		sdaPrev = 1'b1;
		inByte  = '0;
		outByte = '0;
		lowByte = 1'b0;
		bitCnt  = 0;
		forever
		begin
			@(posedge iSysClk);
			#1;	// Lines settled, pull changes away from the DUT edge
			sclNow = scl;
			sdaNow = sda;
			if (!rstN)
			begin
				mode    = modeIdle;
				sdaPull = 1'b0;
			end
			else if (sclPrev && sclNow && sdaPrev && !sdaNow)
			begin
				mode    = modeAdrs;	// START
				bitCnt  = 0;
				sdaPull = 1'b0;
			end
			else if (sclPrev && sclNow && !sdaPrev && sdaNow)
			begin
				mode    = modeIdle;	// STOP
				sdaPull = 1'b0;
			end
			else if (!sclPrev && sclNow)
				sclRise();
			else if (sclPrev && !sclNow)
				sclFall();
			sclPrev = sclNow;
			sdaPrev = sdaNow;
		end
	end

	// Sampling edge
	task sclRise;
		case (mode)
			modeAdrs:
			begin
				inByte = {inByte[6:0], sdaNow};	// MSB first
				bitCnt++;
			end
			modeSend: bitCnt++;
			modeMack:
			begin
				if (!sdaNow && !lowByte)
				begin
					lowByte = 1'b1;	// Master wants the low byte
					mode    = modeLoad;
				end
				else
					mode = modeIdle;	// NACK ends the read
			end
			default: ;
		endcase
	endtask

	// Driving edge, SDA only changes while SCL is low
	task sclFall;
		case (mode)
			modeAdrs:
			begin
				if (bitCnt == 8)
				begin
					if (respondAdrs && (inByte == {keypadAdrs, 1'b1}))
					begin
						sdaPull = 1'b1;	// Address ACK
						lowByte = 1'b0;
						mode    = modeLoad;
					end
					else
						mode = modeIdle;
				end
			end
			modeLoad:
			begin
				outByte = lowByte ? keyWord[7:0] : keyWord[15:8];
				sdaPull = !outByte[7];
				bitCnt  = 0;
				mode    = modeSend;
			end
			modeSend:
			begin
				if (bitCnt == 8)
				begin
					sdaPull = 1'b0;	// Master owns the ACK bit
					mode    = modeMack;
				end
				else
					sdaPull = !outByte[7 - bitCnt];
			end
			default: ;
		endcase
	endtask

endmodule

//--- dv/tbI2cTop.sv
// Testbench for the keypad poller: register access, keypad polling, address NACK, SCL timing, disable
module tbI2cTop;
	timeunit 1ns;
	timeprecision 100ps;
	import i2cBusPkg::*;

	localparam int                divBits     = 16;
	localparam logic [blockW-1:0] blockAdrs   = 24'h000004;	// DUT default
	localparam logic [ofsW-1:0]   unmappedOfs = 8'h40;
	localparam int                pollDiv     = 3;
	localparam int                numWords    = 4;
	// About three transactions per word, plus NACK, SCL measurement and disable
	localparam longint            numTxn      = numWords * 3 + 8;
	localparam longint            txnNs       = 45 * 4 * (pollDiv + 1) * 8;
	localparam longint            marginNs    = 100_000;

	// Expected register contents
	typedef struct packed {
		logic               enable;
		logic [divBits-1:0] div;
		logic [15:0]        key;
		logic               done;
		logic               nack;
	} regModelT;

	logic                iSysClk;
	logic                rstN;
	logic                wbCyc;
	logic                wbStb;
	logic                wbWe;
	logic [busAdrsW-1:0] wbAdr;
	logic [busDataW-1:0] wbDatW;
	logic [busDataW-1:0] wbDatR;
	logic                wbAck;
	logic                sclOe;
	logic                sdaOe;
	logic                sclLine;
	logic                sdaLine;
	logic                modelPull;
	logic                respondAdrs;
	logic [15:0]         modelWord;
	logic [31:0]         lfsrState;
	regModelT            expState;
	int                  accessCount = 0;
	int                  ackCount = 0;
	int                  checksIssued = 0;
	int                  checksDone = 0;
	string               nameQ[$];	// Reads waiting for the checker
	logic [busDataW-1:0] expQ[$];
	logic [busDataW-1:0] actQ[$];
	event                readDone;

	// Pull-ups on both lines
	assign sclLine = !sclOe;
	assign sdaLine = !(sdaOe || modelPull);

	i2cTop #(.pDivBits(divBits)) dut (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAdr   (wbAdr),
		.wbDatW  (wbDatW),
		.wbDatR  (wbDatR),
		.wbAck   (wbAck),
		.sdaIn   (sdaLine),
		.sclOe   (sclOe),
		.sdaOe   (sdaOe)
	);

	i2cKeypadModel model (
		.iSysClk     (iSysClk),
		.rstN        (rstN),
		.scl         (sclLine),
		.sda         (sdaLine),
		.respondAdrs (respondAdrs),
		.keyWord     (modelWord),
		.sdaPull     (modelPull)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #4 iSysClk = ~iSysClk;	// 8 ns period
	end

	always @(posedge iSysClk)
	begin
		if (wbAck)
			ackCount = ackCount + 1;
	end

	// ----------------------------------------------------------
	// Reference model and checks
	// ----------------------------------------------------------
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] nextRandom(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);	// One step per bit
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] expectedRead(input logic [ofsW-1:0] ofs, input regModelT m);
		case (ofs)
			CtrlOfs: return {31'd0, m.enable};
			DivOfs:  return {16'd0, m.div};
			KeyOfs:  return {16'd0, m.key};
			StatOfs: return {30'd0, m.nack, m.done};
			default: return '0;	// Unmapped reads zero
		endcase
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			failRun($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual));
	endtask

	// Compares queued reads as they arrive
	initial
	begin
		forever
		begin
			@(readDone);
			while (actQ.size() > 0)
			begin
				checkValue(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
				checksDone++;
			end
		end
	end

	initial
	begin
		#(numTxn * txnNs + marginNs);
		failRun("timeout waiting for transaction");
	end

	// ----------------------------------------------------------
	// Bus tasks, all start 1 ns after a rising edge
	// ----------------------------------------------------------
	task automatic stepCycle;
		@(posedge iSysClk);
		#1;
	endtask

	task automatic busAccess(input logic we, input logic [ofsW-1:0] ofs,
		input logic [31:0] datW, output logic [31:0] datR);
		csrAdrsT adrs;
		int      waitCycles;
		adrs.field.blockNum = blockAdrs;
		adrs.field.regOfs   = ofs;
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = we;
		wbAdr  = adrs.word;
		wbDatW = datW;
		accessCount++;
		waitCycles = 0;
		do
		begin
			stepCycle();
			waitCycles++;
			if (waitCycles > 4)
				failRun("no Wishbone ack for an access inside the block");
		end
		while (!wbAck);
		datR  = wbDatR;	// Valid with ack
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
		stepCycle();
		checkValue("ack count", accessCount, ackCount);	// One ack per strobe
	endtask

	task automatic busWrite(input logic [ofsW-1:0] ofs, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, ofs, data, unused);
	endtask

	task automatic readAndCheck(input string name, input logic [ofsW-1:0] ofs);
		logic [31:0] data;
		busAccess(1'b0, ofs, '0, data);
		nameQ.push_back(name);
		expQ.push_back(expectedRead(ofs, expState));
		actQ.push_back(data);
		checksIssued++;
		-> readDone;
	endtask

	// Polls Stat until the bit is set
	task automatic waitStatBit(input int bitIdx);
		logic [31:0] stat;
		stat = '0;
		while (!stat[bitIdx])
			busAccess(1'b0, StatOfs, '0, stat);
	endtask

	// SCL high run of the first address bit after a START
	task automatic sclHighCycles(output int cycles);
		logic sclPrev;
		logic sdaPrev;
		sclPrev = 1'b0;
		sdaPrev = 1'b0;
		while (!(sclPrev && sclLine && sdaPrev && !sdaLine))
		begin
			sclPrev = sclLine;
			sdaPrev = sdaLine;
			stepCycle();
		end
		while (sclLine)
			stepCycle();
		while (!sclLine)
			stepCycle();
		cycles = 0;
		while (sclLine)
		begin
			cycles++;
			stepCycle();
		end
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial
	begin
		logic [31:0] r;
		int          highCycles;
		int          quiet;
		rstN        = 1'b0;
		wbCyc       = 1'b0;
		wbStb       = 1'b0;
		wbWe        = 1'b0;
		wbAdr       = '0;
		wbDatW      = '0;
		respondAdrs = 1'b1;
		modelWord   = '0;
		lfsrState   = 32'h362e;
		expState    = '0;
		expState.div = '1;
		repeat (5) @(posedge iSysClk);
		#1;
		rstN = 1'b1;
		stepCycle();

		// Reset values, bus released
		readAndCheck("reset Ctrl", CtrlOfs);
		readAndCheck("reset Div", DivOfs);
		readAndCheck("reset Key", KeyOfs);
		readAndCheck("reset Stat", StatOfs);
		repeat (20)
		begin
			stepCycle();
			checkValue("bus idle while disabled", 32'd0, {30'd0, sclOe, sdaOe});
		end

		r = nextRandom(32);
		busWrite(DivOfs, r);
		expState.div = r[divBits-1:0];
		readAndCheck("random Div", DivOfs);
		r = nextRandom(32);
		busWrite(CtrlOfs, {r[31:1], 1'b0});	// Only bit 0 sticks
		readAndCheck("random Ctrl with enable clear", CtrlOfs);
		readAndCheck("unmapped offset", unmappedOfs);

		// Keypad polling at Div 3
		busWrite(DivOfs, pollDiv);
		expState.div = divBits'(pollDiv);
		readAndCheck("Div for polling", DivOfs);
		r = nextRandom(32);
		busWrite(CtrlOfs, {r[31:1], 1'b1});
		expState.enable = 1'b1;
		readAndCheck("random Ctrl with enable set", CtrlOfs);
		for (int i = 0; i < numWords; i++)
		begin
			r = nextRandom(16);
			modelWord = r[15:0];
			busWrite(StatOfs, 32'h1);
			waitStatBit(0);	// May still hold the old word
			busWrite(StatOfs, 32'h1);
			waitStatBit(0);	// Whole read after the change
			expState.key  = modelWord;
			expState.done = 1'b1;
			readAndCheck("done after poll", StatOfs);
			readAndCheck("keypad word", KeyOfs);
			busWrite(StatOfs, 32'h1);
			expState.done = 1'b0;
			readAndCheck("done cleared", StatOfs);
		end

		// Address NACK
		respondAdrs = 1'b0;
		busWrite(StatOfs, 32'h3);
		waitStatBit(1);
		busWrite(StatOfs, 32'h3);
		waitStatBit(1);
		expState.nack = 1'b1;
		readAndCheck("nack set and done clear", StatOfs);
		readAndCheck("Key kept after NACK", KeyOfs);

		sclHighCycles(highCycles);
		checkValue("SCL high cycles", 2 * (pollDiv + 1), highCycles);

		// Disable, then the bus must stay released
		busWrite(CtrlOfs, 32'h0);
		expState.enable = 1'b0;
		readAndCheck("enable cleared", CtrlOfs);
		quiet = 0;
		while (quiet < 8 * (pollDiv + 1))	// Longer than any gap between transactions
		begin
			stepCycle();
			quiet = (sclOe || sdaOe) ? 0 : quiet + 1;
		end
		repeat (100 * (pollDiv + 1))
		begin
			stepCycle();
			checkValue("bus idle after disable", 32'd0, {30'd0, sclOe, sdaOe});
		end

		@(posedge iSysClk);
		if (checksDone == checksIssued)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			failRun("checker left reads uncompared");
	end

endmodule

//--- sim.f
design/i2cBusPkg.sv
design/i2cProtoPkg.sv
design/i2cBitIf.sv
design/i2cCsr.sv
design/i2cBitEngine.sv
design/i2cPollSeq.sv
design/i2cTop.sv
dv/i2cKeypadModel.sv
dv/tbI2cTop.sv
